//--- Makefile
# Verilator build and run for the 3x3 filter pipeline

VERILATOR  ?= verilator
TOP        ?= filterTb
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing

PASS_TEXT  = TEST RESULT: PASS
FAIL_TEXT  = TEST RESULT: FAIL

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then echo "Simulation reported errors"; exit 1; fi
	@if ! grep -q "$(PASS_TEXT)" $(LOG); then echo "Simulation ended without a verdict"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/filterChecker.sv
`timescale 1ns/1ps

module filterChecker import filterPkg::*; #(
  parameter int lineLength = 16
) (
  input  logic        clock,
  input  logic        reset,
  input  logic        pixelValid,
  input  pixel_t      pixelIn,
  input  logic        pixelReady,
  input  filterMode_t mode,
  input  logic        outValid,
  input  pixel_t      outPixel,
  input  logic        outReady,
  output int          acceptCount,
  output int          beatCount,
  output int          valueErrors,
  output int          protocolErrors
);

  localparam int MaxValue = (1 << PixelWidth) - 1;

  int     pixelHistory [$];
  int     modeHistory [$];
  logic   afterReset;
  logic   stalled;
  pixel_t heldPixel;

  // ====================================================================
  // Reference model
  // ====================================================================

  // Pixel c + r*lineLength accepts before pixel n, zero before the stream
  function automatic int tapValue(int n, int col, int row);
    int index;
    index = n - col - row * lineLength;
    if (index < 0) return 0;
    return pixelHistory[index];
  endfunction

  function automatic int scaleSaturate(int value);
    if (value >= 4 * (MaxValue + 1)) return MaxValue;
    return value / 4;
  endfunction

  // Middle weight 2 gives Sobel, 1 gives Prewitt
  function automatic int gradientModel(int n, int midWeight);
    int left;
    int right;
    int top;
    int bottom;
    left   = tapValue(n, 0, 0) + midWeight * tapValue(n, 0, 1) + tapValue(n, 0, 2);
    right  = tapValue(n, 2, 0) + midWeight * tapValue(n, 2, 1) + tapValue(n, 2, 2);
    top    = tapValue(n, 0, 0) + midWeight * tapValue(n, 1, 0) + tapValue(n, 2, 0);
    bottom = tapValue(n, 0, 2) + midWeight * tapValue(n, 1, 2) + tapValue(n, 2, 2);
    return scaleSaturate(((left > right) ? left - right : right - left)
                       + ((top > bottom) ? top - bottom : bottom - top));
  endfunction

  function automatic int expectedBeat(int beat);
    int n;
    int total;
    int laplace;
    n     = beat - 2;
    total = 0;
    for (int row = 0; row < 3; row++) begin
      for (int col = 0; col < 3; col++) begin
        total += tapValue(n, col, row);
      end
    end
    laplace = 4 * tapValue(n, 1, 1) - tapValue(n, 1, 0) - tapValue(n, 0, 1)
            - tapValue(n, 2, 1) - tapValue(n, 1, 2);
    case (modeHistory[beat])
      0: return tapValue(n, 0, 0);
      1: return gradientModel(n, 2);
      2: return gradientModel(n, 1);
      3: return scaleSaturate(total);
      4: return total / 9;
      5: return (laplace < 0) ? MaxValue : laplace / 4;
      default: return 0;
    endcase
  endfunction

  task automatic checkBeat();
    int expected;
    if (beatCount >= acceptCount) begin
      $display("Time %0t: output beat %0d has no accepted pixel behind it", $time, beatCount);
      protocolErrors++;
    end else begin
      expected = expectedBeat(beatCount);
      if (int'(outPixel) != expected) begin
        $display("FAIL time=%0t outPixel expected=%0d actual=%0d (beat %0d, mode %0d)",
                 $time, expected, outPixel, beatCount, modeHistory[beatCount]);
        valueErrors++;
      end
    end
    beatCount++;
  endtask

  // ====================================================================
  // Monitor
  // ====================================================================

  always @(posedge clock) begin
    if (reset) begin
      acceptCount    = 0;
      beatCount      = 0;
      valueErrors    = 0;
      protocolErrors = 0;
      afterReset     = 1'b1;
      stalled        = 1'b0;
      pixelHistory.delete();
      modeHistory.delete();
    end else begin
      if (afterReset && (outValid || !pixelReady)) begin
        $display("Time %0t: pipeline not idle in the first cycle after reset", $time);
        protocolErrors++;
      end
      if (pixelReady != (!outValid || outReady)) begin
        $display("FAIL time=%0t pixelReady expected=%0b actual=%0b",
                 $time, !outValid || outReady, pixelReady);
        protocolErrors++;
      end
      if (stalled && !outValid) begin
        $display("Time %0t: held output beat vanished under back-pressure", $time);
        protocolErrors++;
      end else if (stalled && outPixel != heldPixel) begin
        $display("FAIL time=%0t outPixel expected=%0d actual=%0d (held beat)",
                 $time, heldPixel, outPixel);
        protocolErrors++;
      end
      // Beat first, its mode was recorded on an earlier accept
      if (outValid && outReady) begin
        checkBeat();
      end
      if (pixelValid && pixelReady) begin
        pixelHistory.push_back(int'(pixelIn));
        modeHistory.push_back(int'(mode));
        acceptCount++;
      end
      afterReset = 1'b0;
      stalled    = outValid && !outReady;
      heldPixel  = outPixel;
    end
  end

endmodule

//--- dv/filterPipeline_asserts.sv
`timescale 1ns/1ps

module filterPipelineAsserts import filterPkg::*; (
  input logic   clock,
  input logic   reset,
  input logic   pixelReady,
  input logic   outValid,
  input pixel_t outPixel,
  input logic   outReady
);

  // Output register empty straight after reset
  resetIdle: assert property (@(posedge clock) reset |=> !outValid)
    else $error("outValid high in the cycle after reset");

  // Input ready follows the output handshake
  readyRule: assert property (@(posedge clock) disable iff (reset)
    pixelReady == (!outValid || outReady))
    else $error("pixelReady does not follow outValid and outReady");

  // Held beat stays put until the sink takes it
  holdUnderStall: assert property (@(posedge clock) disable iff (reset)
    (outValid && !outReady) |=> (outValid && $stable(outPixel)))
    else $error("output beat changed or dropped under back-pressure");

endmodule

bind filterPipeline filterPipelineAsserts handshakeAsserts (
  .clock     (clock),
  .reset     (reset),
  .pixelReady(pixelReady),
  .outValid  (outValid),
  .outPixel  (outPixel),
  .outReady  (outReady)
);

//--- dv/filterTb.sv
`timescale 1ns/1ps

module filterTb import filterPkg::*; ();

  localparam int LineLength     = 16;
  localparam int StimulusLength = 600;
  localparam int ResetCycles    = 4;
  localparam int CycleLimit     = 4 * StimulusLength + ResetCycles;

  logic        clock;
  logic        reset;
  logic        pixelValid;
  pixel_t      pixelIn;
  logic        pixelReady;
  filterMode_t mode;
  logic        outValid;
  pixel_t      outPixel;
  logic        outReady;
  int          acceptCount;
  int          beatCount;
  int          valueErrors;
  int          protocolErrors;
  int          seed;
  int          cycleCount = 0;
  logic        timedOut;
  logic        finished;

  filterPipeline #(.lineLength(LineLength)) uut (
    .clock(clock), .reset(reset), .pixelValid(pixelValid), .pixelIn(pixelIn),
    .pixelReady(pixelReady), .mode(mode), .outValid(outValid),
    .outPixel(outPixel), .outReady(outReady)
  );

  filterChecker #(.lineLength(LineLength)) scoreboard (
    .clock(clock), .reset(reset), .pixelValid(pixelValid), .pixelIn(pixelIn),
    .pixelReady(pixelReady), .mode(mode), .outValid(outValid),
    .outPixel(outPixel), .outReady(outReady), .acceptCount(acceptCount),
    .beatCount(beatCount), .valueErrors(valueErrors), .protocolErrors(protocolErrors)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  always @(posedge clock) begin
    cycleCount <= cycleCount + 1;
  end

  // Binary burst for strong edges, then a flat bright patch
  function automatic pixel_t pixelForAccept(int index);
    int draw;
    draw = $random(seed);
    if (index >= 200 && index < 350) return (draw & 1) ? PixelMax : '0;
    if (index >= 350 && index < 400) return PixelMax;
    return pixel_t'(draw);
  endfunction

  task automatic driveCycle();
    pixelValid = (acceptCount < StimulusLength) && (($random(seed) & 3) != 0);
    pixelIn    = pixelForAccept(acceptCount);
    mode       = filterMode_t'($random(seed) & 7);
    outReady   = ($random(seed) & 3) != 0;
  endtask

  // ====================================================================
  // Main sequence
  // ====================================================================

  initial begin
    seed       = 47187;
    reset      = 1'b1;
    pixelValid = 1'b0;
    pixelIn    = '0;
    mode       = modePass;
    outReady   = 1'b0;
    timedOut   = 1'b0;
    finished   = 1'b0;
    repeat (ResetCycles) @(negedge clock);
    reset = 1'b0;
    while (!finished && !timedOut) begin
      driveCycle();
      @(negedge clock);
      if (acceptCount == StimulusLength && beatCount == StimulusLength) begin
        finished = 1'b1;
      end else if (cycleCount >= CycleLimit) begin
        timedOut = 1'b1;
      end
    end
    pixelValid = 1'b0;
    outReady   = 1'b0;
    if (timedOut) begin
      $display("Timeout after %0d cycles with %0d accepts and %0d beats done",
               cycleCount, acceptCount, beatCount);
    end
    $display("Errors: %0d value, %0d protocol, %0d timeout", valueErrors,
             protocolErrors, timedOut);
    if (valueErrors == 0 && protocolErrors == 0 && !timedOut) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- files.f
logic/filterPkg.sv
logic/lineWindow.sv
logic/gradientKernel.sv
logic/neighborhoodKernel.sv
logic/resultSelect.sv
logic/filterPipeline.sv
dv/filterPipeline_asserts.sv
dv/filterChecker.sv
dv/filterTb.sv

//--- logic/filterPipeline.sv
`timescale 1ns/1ps

module filterPipeline import filterPkg::*; #(
  parameter int lineLength = 800
) (
  input  logic        clock,
  input  logic        reset,
  input  logic        pixelValid,
  input  pixel_t      pixelIn,
  output logic        pixelReady,
  input  filterMode_t mode,
  output logic        outValid,
  output pixel_t      outPixel,
  input  logic        outReady
);

  logic    advance;
  window_t window;
  pixel_t  sobelPixel;
  pixel_t  prewittPixel;
  pixel_t  boxSumPixel;
  pixel_t  meanPixel;
  pixel_t  laplacianPixel;
  pixel_t  passPixel;

  lineWindow #(
    .lineLength(lineLength)
  ) window3x3 (
    .clock  (clock),
    .reset  (reset),
    .advance(advance),
    .pixelIn(pixelIn),
    .window (window)
  );

  gradientKernel gradient (
    .clock       (clock),
    .reset       (reset),
    .advance     (advance),
    .window      (window),
    .sobelPixel  (sobelPixel),
    .prewittPixel(prewittPixel)
  );

  neighborhoodKernel neighborhood (
    .clock         (clock),
    .reset         (reset),
    .advance       (advance),
    .window        (window),
    .boxSumPixel   (boxSumPixel),
    .meanPixel     (meanPixel),
    .laplacianPixel(laplacianPixel),
    .passPixel     (passPixel)
  );

  resultSelect select (
    .clock         (clock),
    .reset         (reset),
    .pixelValid    (pixelValid),
    .pixelReady    (pixelReady),
    .advance       (advance),
    .mode          (mode),
    .passPixel     (passPixel),
    .sobelPixel    (sobelPixel),
    .prewittPixel  (prewittPixel),
    .boxSumPixel   (boxSumPixel),
    .meanPixel     (meanPixel),
    .laplacianPixel(laplacianPixel),
    .outValid      (outValid),
    .outPixel      (outPixel),
    .outReady      (outReady)
  );

endmodule

//--- logic/filterPkg.sv
package filterPkg;

  // ====================================================================
  // Widths and types
  // ====================================================================

  localparam int PixelWidth = 10;
  localparam int TapCount   = 9;
  localparam int WindowSize = 3;

  typedef logic [PixelWidth-1:0]          pixel_t;
  typedef logic [TapCount*PixelWidth-1:0] window_t;

  // Kernel arithmetic, wide enough for sums plus a sign or overflow bit
  typedef logic [PixelWidth+2:0] sum_t;

  localparam pixel_t PixelMax = '1;

  // Codes 6 and 7 are unused and select zero
  typedef enum logic [2:0] {
    modePass      = 3'd0,
    modeSobel     = 3'd1,
    modePrewitt   = 3'd2,
    modeBoxSum    = 3'd3,
    modeMean      = 3'd4,
    modeLaplacian = 3'd5
  } filterMode_t;

  // Col 0 is the newest pixel, row 0 the current line
  function automatic int tapIndex(int col, int row);
    return col + WindowSize * row;
  endfunction

  function automatic pixel_t tapAt(window_t window, int col, int row);
    return window[tapIndex(col, row)*PixelWidth +: PixelWidth];
  endfunction

endpackage

//--- logic/gradientKernel.sv
`timescale 1ns/1ps

module gradientKernel import filterPkg::*; (
  input  logic    clock,
  input  logic    reset,
  input  logic    advance,
  input  window_t window,
  output pixel_t  sobelPixel,
  output pixel_t  prewittPixel
);

  // Sum of absolute differences, scaled down by 4
  function automatic pixel_t gradientMag(sum_t left, sum_t right, sum_t top, sum_t bottom);
    sum_t dx;
    sum_t dy;
    sum_t total;
    dx    = (left > right) ? left - right : right - left;
    dy    = (top > bottom) ? top - bottom : bottom - top;
    total = dx + dy;
    if (total[PixelWidth+2]) begin
      return PixelMax;
    end
    return total[PixelWidth+1:2];
  endfunction

  pixel_t magnitude [2];

  // ====================================================================
  // Directional sums, kernel 0 is Sobel and kernel 1 Prewitt
  // ====================================================================

  for (genvar k = 0; k < 2; k++) begin : gKernel
    // Middle tap weight is 2 for Sobel
    localparam int MidShift = (k == 0) ? 1 : 0;

    sum_t leftSum;
    sum_t rightSum;
    sum_t topSum;
    sum_t bottomSum;

    always_ff @(posedge clock) begin
      if (reset) begin
        leftSum   <= '0;
        rightSum  <= '0;
        topSum    <= '0;
        bottomSum <= '0;
      end else if (advance) begin
        leftSum   <= sum_t'(tapAt(window, 0, 0))
                   + (sum_t'(tapAt(window, 0, 1)) << MidShift)
                   + sum_t'(tapAt(window, 0, 2));
        rightSum  <= sum_t'(tapAt(window, 2, 0))
                   + (sum_t'(tapAt(window, 2, 1)) << MidShift)
                   + sum_t'(tapAt(window, 2, 2));
        topSum    <= sum_t'(tapAt(window, 0, 0))
                   + (sum_t'(tapAt(window, 1, 0)) << MidShift)
                   + sum_t'(tapAt(window, 2, 0));
        bottomSum <= sum_t'(tapAt(window, 0, 2))
                   + (sum_t'(tapAt(window, 1, 2)) << MidShift)
                   + sum_t'(tapAt(window, 2, 2));
      end
    end

    assign magnitude[k] = gradientMag(leftSum, rightSum, topSum, bottomSum);
  end

  assign sobelPixel   = magnitude[0];
  assign prewittPixel = magnitude[1];

endmodule

//--- logic/lineWindow.sv
`timescale 1ns/1ps

module lineWindow import filterPkg::*; #(
  parameter int lineLength = 800
) (
  input  logic    clock,
  input  logic    reset,
  input  logic    advance,
  input  pixel_t  pixelIn,
  output window_t window
);

  // Three pixels of each line already sit in the tap registers,
  // so the row memory supplies the rest of the line delay
  localparam int MemDepth = lineLength - WindowSize;
  localparam int PtrWidth = (MemDepth > 1) ? $clog2(MemDepth) : 1;
  localparam logic [PtrWidth-1:0] PtrLast = PtrWidth'(MemDepth - 1);

  // Oldest taps of rows 0 and 1, row 0 in the low half
  typedef logic [2*PixelWidth-1:0] rowPair_t;

  pixel_t              taps [TapCount];
  rowPair_t            rowMem [MemDepth];
  rowPair_t            rowRead;
  logic [PtrWidth-1:0] wrapPtr;
  logic                memFilled;

  // ====================================================================
  // Circular row memory
  // ====================================================================

  // Entries written before the first wrap are not yet valid lines
  assign rowRead = memFilled ? rowMem[wrapPtr] : '0;

  always_ff @(posedge clock) begin
    if (advance) begin
      rowMem[wrapPtr] <= {taps[tapIndex(2, 1)], taps[tapIndex(2, 0)]};
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wrapPtr   <= '0;
      memFilled <= 1'b0;
    end else if (advance) begin
      if (wrapPtr == PtrLast) begin
        wrapPtr   <= '0;
        memFilled <= 1'b1;
      end else begin
        wrapPtr <= wrapPtr + 1'b1;
      end
    end
  end

  // ====================================================================
  // Tap registers
  // ====================================================================

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < TapCount; i++) begin
        taps[i] <= '0;
      end
    end else if (advance) begin
      // Newest column of each row
      taps[tapIndex(0, 0)] <= pixelIn;
      taps[tapIndex(0, 1)] <= rowRead[PixelWidth-1:0];
      taps[tapIndex(0, 2)] <= rowRead[2*PixelWidth-1:PixelWidth];
      // Older columns shift along their row
      for (int row = 0; row < WindowSize; row++) begin
        for (int col = 1; col < WindowSize; col++) begin
          taps[tapIndex(col, row)] <= taps[tapIndex(col - 1, row)];
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < TapCount; i++) begin
      window[i*PixelWidth +: PixelWidth] = taps[i];
    end
  end

endmodule

//--- logic/neighborhoodKernel.sv
`timescale 1ns/1ps

module neighborhoodKernel import filterPkg::*; (
  input  logic    clock,
  input  logic    reset,
  input  logic    advance,
  input  window_t window,
  output pixel_t  boxSumPixel,
  output pixel_t  meanPixel,
  output pixel_t  laplacianPixel,
  output pixel_t  passPixel
);

  // Nine maximum pixels overflow sum_t by one bit
  typedef logic [$bits(sum_t):0] boxTotal_t;

  sum_t      rowSum [WindowSize];
  sum_t      edgeSum;
  pixel_t    centerTap;
  pixel_t    passTap;
  boxTotal_t boxTotal;
  sum_t      laplace;

  // ====================================================================
  // Registered partial sums
  // ====================================================================

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int row = 0; row < WindowSize; row++) begin
        rowSum[row] <= '0;
      end
      edgeSum   <= '0;
      centerTap <= '0;
      passTap   <= '0;
    end else if (advance) begin
      for (int row = 0; row < WindowSize; row++) begin
        rowSum[row] <= sum_t'(tapAt(window, 0, row))
                     + sum_t'(tapAt(window, 1, row))
                     + sum_t'(tapAt(window, 2, row));
      end
      // Four edge neighbors of the center
      edgeSum   <= sum_t'(tapAt(window, 1, 0)) + sum_t'(tapAt(window, 0, 1))
                 + sum_t'(tapAt(window, 2, 1)) + sum_t'(tapAt(window, 1, 2));
      centerTap <= tapAt(window, 1, 1);
      // Unfiltered pixel, one advance behind like the other results
      passTap   <= tapAt(window, 0, 0);
    end
  end

  // ====================================================================
  // Results
  // ====================================================================

  assign boxTotal = boxTotal_t'(rowSum[0]) + boxTotal_t'(rowSum[1])
                  + boxTotal_t'(rowSum[2]);

  // Saturates once the sum reaches four times the pixel range
  assign boxSumPixel = (boxTotal >= boxTotal_t'(1 << (PixelWidth + 2))) ? PixelMax
                     : boxTotal[PixelWidth+1:2];

  assign meanPixel = pixel_t'(boxTotal / 9);

  // Top bit is the sign of the difference
  assign laplace        = (sum_t'(centerTap) << 2) - edgeSum;
  assign laplacianPixel = laplace[PixelWidth+2] ? PixelMax : laplace[PixelWidth+1:2];

  assign passPixel = passTap;

endmodule

//--- logic/resultSelect.sv
`timescale 1ns/1ps

module resultSelect import filterPkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        pixelValid,
  output logic        pixelReady,
  output logic        advance,
  input  filterMode_t mode,
  input  pixel_t      passPixel,
  input  pixel_t      sobelPixel,
  input  pixel_t      prewittPixel,
  input  pixel_t      boxSumPixel,
  input  pixel_t      meanPixel,
  input  pixel_t      laplacianPixel,
  output logic        outValid,
  output pixel_t      outPixel,
  input  logic        outReady
);

  pixel_t selected;

  // Whole pipeline moves only on an accepted input pixel
  assign pixelReady = ~outValid | outReady;
  assign advance    = pixelValid & pixelReady;

  always_comb begin
    case (mode)
      modePass:      selected = passPixel;
      modeSobel:     selected = sobelPixel;
      modePrewitt:   selected = prewittPixel;
      modeBoxSum:    selected = boxSumPixel;
      modeMean:      selected = meanPixel;
      modeLaplacian: selected = laplacianPixel;
      default:       selected = '0;
    endcase
  end

  // ====================================================================
  // Output register
  // ====================================================================

  always_ff @(posedge clock) begin
    if (reset) begin
      outValid <= 1'b0;
      outPixel <= '0;
    end else if (advance) begin
      outValid <= 1'b1;
      outPixel <= selected;
    end else if (outReady) begin
      // Beat taken with nothing new behind it
      outValid <= 1'b0;
    end
  end

endmodule
